//--- hw/bikeDrivePkg.sv
/*
 * Shared definitions for the tilt-controlled drive path.
 * Holds the tilt sample type, PWM timing constants,
 * the dead-zone threshold, filter depth and motor pedestal.
 */

`default_nettype none

package bikeDrivePkg;

	// Accelerometer tilt samples are signed two's-complement words
	localparam int SAMPLE_W = 10;

	typedef logic signed [SAMPLE_W-1:0] tiltSample_t;

	// System clock cycles per PWM tick, so one tick is 2.56 us at 50 MHz
	localparam int TICK_DIV = 128;

	// Width of the prescaler counter that spans one tick
	localparam int TICK_W = $clog2(TICK_DIV);

	// Ticks per PWM frame, and the frame counter runs from 0 to PWM_PERIOD-1
	localparam int PWM_PERIOD = 531;

	// Width of the frame counter inside each PWM channel
	localparam int FRAME_W = $clog2(PWM_PERIOD);

	// A setting at or below this value forces the channel output low
	localparam int DEAD_ZONE = 12;

	// Number of samples in the moving average, kept a power of two
	localparam int FILTER_TAPS = 4;

	// Right shift that turns the running sum into the average
	localparam int AVG_SHIFT = $clog2(FILTER_TAPS);

	// The running sum grows by AVG_SHIFT bits so it can never overflow
	localparam int SUM_W = SAMPLE_W + AVG_SHIFT;

	// Duty pedestal that gets the motor turning smoothly from standstill
	localparam int MOTOR_OFFSET = 250;

endpackage

`default_nettype wire

//--- hw/pwmPrescaler.sv
/*
 * PWM tick prescaler.
 * Divides CLOCK_50 by TICK_DIV and emits a single-cycle
 * tick enable that both PWM channels share.
 */

`timescale 1ns/1ps
`default_nettype none

module pwmPrescaler
	import bikeDrivePkg::*;
(
	input  logic CLOCK_50,
	input  logic arstN,
	output logic tick
);

	// Free-running divider count within one tick period
	logic [TICK_W-1:0] divCount;

	// High on the last cycle of each tick period
	logic divWrap;

	always_comb
	begin
		divWrap = (divCount == TICK_W'(TICK_DIV - 1));
	end

	// The counter wraps explicitly so a TICK_DIV that is not a power of two also works
	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			divCount <= '0;
		end
		else if (divWrap)
		begin
			divCount <= '0;
		end
		else
		begin
			divCount <= divCount + 1'b1;
		end
	end

	// Tick is registered, so the first one appears TICK_DIV cycles after reset release
	// It stays high for exactly one cycle per period
	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			tick <= 1'b0;
		end
		else
		begin
			tick <= divWrap;
		end
	end

endmodule

`default_nettype wire

//--- hw/tiltFilter.sv
/*
 * Moving-average filter for strobed tilt samples.
 * Keeps the last FILTER_TAPS samples and a running sum,
 * and outputs the floored average held between strobes.
 */

`timescale 1ns/1ps
`default_nettype none

module tiltFilter
	import bikeDrivePkg::*;
(
	input  logic        CLOCK_50,
	input  logic        arstN,
	input  tiltSample_t accelSample,
	input  logic        accelStrobe,
	output tiltSample_t tiltAvg
);

	// Sample history, where tap 0 is the newest and the last tap is the oldest
	tiltSample_t taps [FILTER_TAPS];

	// Sum of all taps, widened so four full-scale samples still fit
	logic signed [SUM_W-1:0] runSum;

	// Sum after the pending strobe is accepted
	logic signed [SUM_W-1:0] sumNext;

	// Average that goes with sumNext
	tiltSample_t avgNext;

	// Drop the oldest sample and add the new one instead of re-adding all taps
	// The size casts sign-extend both samples into the wider sum
	always_comb
	begin
		sumNext = runSum - SUM_W'(taps[FILTER_TAPS-1]) + SUM_W'(accelSample);
	end

	// Arithmetic shift floors toward minus infinity, so -1/4 becomes -1
	// After the shift the value always fits back into a sample
	always_comb
	begin
		avgNext = tiltSample_t'(sumNext >>> AVG_SHIFT);
	end

	// History shifts by one tap per strobe
	// Strobes on back-to-back cycles are each taken, and nothing is ever refused
	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < FILTER_TAPS; i++)
			begin
				taps[i] <= '0;
			end
		end
		else if (accelStrobe)
		begin
			for (int i = FILTER_TAPS - 1; i > 0; i--)
			begin
				taps[i] <= taps[i-1];
			end
			taps[0] <= accelSample;
		end
	end

	// Sum and average move together, so tiltAvg is valid one cycle after the strobe
	// Between strobes the average holds its last value
	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			runSum  <= '0;
			tiltAvg <= '0;
		end
		else if (accelStrobe)
		begin
			runSum  <= sumNext;
			tiltAvg <= avgNext;
		end
	end

endmodule

`default_nettype wire

//--- hw/pwmGenerator.sv
/*
 * Tick-driven PWM channel.
 * Frame counter, setting derivation with optional magnitude mode,
 * dead-zone blanking, duty pedestal and the registered output.
 */

`timescale 1ns/1ps
`default_nettype none

module pwmGenerator
	import bikeDrivePkg::*;
#(
	// Duty pedestal in ticks that is added to every non-blanked setting
	parameter int offset = 0,
	// When set, negative levels drive the output by their magnitude
	parameter bit negEnable = 1'b0
)
(
	input  logic        CLOCK_50,
	input  logic        arstN,
	input  logic        tick,
	input  tiltSample_t level,
	output logic        pwm
);

	// Position within the PWM frame, counted in ticks
	logic [FRAME_W-1:0] frameCount;

	// Last tick of the frame, where the counter wraps back to zero
	logic frameEnd;

	// Unsigned setting derived from the signed level
	// Magnitude of the most negative sample is 512, which still fits in SAMPLE_W bits
	logic [SAMPLE_W-1:0] setting;

	// Number of high ticks at the start of each frame
	int dutyTicks;

	// Output level for the current frame position
	logic pwmNext;

	always_comb
	begin
		frameEnd = (frameCount == FRAME_W'(PWM_PERIOD - 1));
	end

	// Positive levels pass straight through
	// Negative levels give their two's-complement magnitude in magnitude mode,
	// otherwise zero so a backward tilt never drives the motor
	always_comb
	begin
		if (!level[SAMPLE_W-1])
		begin
			setting = unsigned'(level);
		end
		else if (negEnable)
		begin
			setting = unsigned'(-level);
		end
		else
		begin
			setting = '0;
		end
	end

	// Pedestal raises the duty floor for the motor channel
	always_comb
	begin
		dutyTicks = int'(setting) + offset;
	end

	// High for the first dutyTicks ticks of the frame
	// A duty of PWM_PERIOD or more keeps the counter always below it, so the frame is full
	// Settings inside the dead zone blank the output whatever the pedestal
	always_comb
	begin
		if (int'(setting) > DEAD_ZONE)
		begin
			pwmNext = (int'(frameCount) < dutyTicks);
		end
		else
		begin
			pwmNext = 1'b0;
		end
	end

	// Counter advances only on ticks, and the comparison uses the value before the step
	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			frameCount <= '0;
		end
		else if (tick)
		begin
			if (frameEnd)
			begin
				frameCount <= '0;
			end
			else
			begin
				frameCount <= frameCount + 1'b1;
			end
		end
	end

	// Output is registered on ticks only, so it changes on the cycle after a tick
	// A new level takes effect at the next tick, even in the middle of a frame
	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			pwm <= 1'b0;
		end
		else if (tick)
		begin
			pwm <= pwmNext;
		end
	end

endmodule

`default_nettype wire

//--- hw/bikeDrive.sv
/*
 * Drive-control top level.
 * Tilt filter, shared tick prescaler, the motor PWM channel
 * with its pedestal and the magnitude-mode indicator LED channel.
 */

`timescale 1ns/1ps
`default_nettype none

module bikeDrive
	import bikeDrivePkg::*;
(
	input  logic                       CLOCK_50,
	input  logic                       arstN,
	input  logic signed [SAMPLE_W-1:0] accelSample,
	input  logic                       accelStrobe,
	output logic                       motorPwm,
	output logic                       tiltLed
);

	// Smoothed tilt, held between sample strobes
	tiltSample_t tiltAvg;

	// One-cycle PWM tick enable shared by both channels
	logic tick;

	// Moving average removes accelerometer jitter before it reaches the motor
	tiltFilter u_filter (
		.CLOCK_50    (CLOCK_50),
		.arstN       (arstN),
		.accelSample (accelSample),
		.accelStrobe (accelStrobe),
		.tiltAvg     (tiltAvg)
	);

	// A single prescaler keeps both channels frame-aligned
	pwmPrescaler u_prescaler (
		.CLOCK_50 (CLOCK_50),
		.arstN    (arstN),
		.tick     (tick)
	);

	// Motor channel with the start-up pedestal, where backward tilt gives no drive
	pwmGenerator #(
		.offset    (MOTOR_OFFSET),
		.negEnable (1'b0)
	) u_motorPwm (
		.CLOCK_50 (CLOCK_50),
		.arstN    (arstN),
		.tick     (tick),
		.level    (tiltAvg),
		.pwm      (motorPwm)
	);

	// LED shows how hard the rider leans in either direction
	pwmGenerator #(
		.offset    (0),
		.negEnable (1'b1)
	) u_ledPwm (
		.CLOCK_50 (CLOCK_50),
		.arstN    (arstN),
		.tick     (tick),
		.level    (tiltAvg),
		.pwm      (tiltLed)
	);

endmodule

`default_nettype wire

//--- bench/bikeDrive_props.sv
/*
 * Concurrent assertions bound into the drive-control top level.
 * Tick width and spacing, output timing and reset behavior.
 */

`timescale 1ns/1ps
`default_nettype none

module bikeDrive_props
	import bikeDrivePkg::*;
(
	input logic CLOCK_50,
	input logic arstN,
	input logic tick,
	input logic motorPwm,
	input logic tiltLed
);

	// Cycles since the last tick, where the cycle after a tick counts as one
	int sinceTick;

	// Set once the first tick after reset has been sampled
	logic seenTick;

	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			sinceTick <= 0;
			seenTick  <= 1'b0;
		end
		else
		begin
			sinceTick <= tick ? 1 : sinceTick + 1;
			seenTick  <= seenTick | tick;
		end
	end

	tickWidth: assert property (@(posedge CLOCK_50) disable iff (!arstN) tick |=> !tick)
		else $error("tick stayed high for more than one cycle");

	// A tick comes exactly when TICK_DIV cycles have passed, never early or late
	tickSpacing: assert property (@(posedge CLOCK_50) disable iff (!arstN)
		tick == (sinceTick == TICK_DIV))
		else $error("tick spacing differs from TICK_DIV cycles");

	motorTiming: assert property (@(posedge CLOCK_50) disable iff (!arstN)
		$changed(motorPwm) |-> $past(tick))
		else $error("motorPwm changed on a cycle that did not follow a tick");

	ledTiming: assert property (@(posedge CLOCK_50) disable iff (!arstN)
		$changed(tiltLed) |-> $past(tick))
		else $error("tiltLed changed on a cycle that did not follow a tick");

	// Holds through reset as well, since seenTick clears asynchronously
	resetLow: assert property (@(posedge CLOCK_50) !seenTick |-> !motorPwm && !tiltLed)
		else $error("PWM output high before the first tick");

endmodule

bind bikeDrive bikeDrive_props u_props (
	.CLOCK_50 (CLOCK_50),
	.arstN    (arstN),
	.tick     (tick),
	.motorPwm (motorPwm),
	.tiltLed  (tiltLed)
);

`default_nettype wire

//--- bench/bikeDriveTb.sv
/*
 * Trace-driven testbench for the drive-control top level.
 * Clock and reset, trace reading, sample strobes, pulse
 * measurement on both PWM outputs, checks and a watchdog.
 */

`timescale 1ns/1ps
`default_nettype none

module bikeDriveTb
	import bikeDrivePkg::*;
();

	localparam int CLK_PERIOD = 8;

	// One PWM frame in clock cycles
	localparam int FRAME_CYCLES = PWM_PERIOD * TICK_DIV;

	logic        CLOCK_50;
	logic        arstN;
	tiltSample_t accelSample;
	logic        accelStrobe;
	logic        motorPwm;
	logic        tiltLed;

	// Trace contents, where testSamples holds FILTER_TAPS entries per test
	string testNames [$];
	int    testSamples [$];
	int    expMotor [$];
	int    expLed [$];

	int numTests = 0;
	int errorCount = 0;
	int failedTests = 0;
	bit traceReady = 1'b0;

	bikeDrive u_dut (
		.CLOCK_50    (CLOCK_50),
		.arstN       (arstN),
		.accelSample (accelSample),
		.accelStrobe (accelStrobe),
		.motorPwm    (motorPwm),
		.tiltLed     (tiltLed)
	);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
		end
	end

	// Pulse length in clock cycles against the expected length
	task automatic checkWidth(input string sigName, input int got, input int expected);
		if (got != expected)
		begin
			$display("Error %s: high time 0x%0h cycles, expected 0x%0h", sigName, got, expected);
			errorCount++;
		end
	endtask

	// Steady output level against the expected level
	task automatic checkLevel(input string sigName, input logic got, input logic expected);
		if (got !== expected)
		begin
			$display("Error %s: level 0x%0h, expected 0x%0h", sigName, got, expected);
			errorCount++;
		end
	endtask

	task automatic reportFailure(input string what);
		$display("%s", what);
		errorCount++;
	endtask

	task automatic readTrace();
		int fd;
		int items;
		int s0;
		int s1;
		int s2;
		int s3;
		int motorTicks;
		int ledTicks;
		logic [8*128-1:0] lineBuf;
		logic [8*32-1:0]  nameBuf;
		fd = $fopen("bench/bikeDriveTrace.txt", "r");
		if (fd == 0)
		begin
			reportFailure("The trace file bench/bikeDriveTrace.txt could not be opened");
			return;
		end
		while (!$feof(fd))
		begin
			lineBuf = '0;
			nameBuf = '0;
			if ($fgets(lineBuf, fd) != 0)
			begin
				items = $sscanf(lineBuf, "%s %d %d %d %d %d %d", nameBuf, s0, s1, s2, s3,
					motorTicks, ledTicks);
				// Comment and blank lines never give all seven fields
				if (items == 7)
				begin
					testNames.push_back($sformatf("%0s", nameBuf));
					testSamples.push_back(s0);
					testSamples.push_back(s1);
					testSamples.push_back(s2);
					testSamples.push_back(s3);
					expMotor.push_back(motorTicks);
					expLed.push_back(ledTicks);
				end
			end
		end
		$fclose(fd);
	endtask

	// Samples at falling edges, where the registered outputs are stable
	// First looks for a rising edge within one frame, then times the high phase
	task automatic measurePulse(input bit useLed, output int width, output bit rose,
		output bit fell, output bit changed, output logic firstLevel);
		logic prev;
		logic cur;
		int   n;
		rose = 1'b0;
		fell = 1'b0;
		changed = 1'b0;
		width = 0;
		@(negedge CLOCK_50);
		prev = useLed ? tiltLed : motorPwm;
		firstLevel = prev;
		n = 0;
		while (!rose && n < FRAME_CYCLES)
		begin
			@(negedge CLOCK_50);
			cur = useLed ? tiltLed : motorPwm;
			if (cur !== firstLevel)
				changed = 1'b1;
			if (!prev && cur)
				rose = 1'b1;
			prev = cur;
			n++;
		end
		if (rose)
		begin
			width = 1;
			while (!fell && width <= FRAME_CYCLES)
			begin
				@(negedge CLOCK_50);
				cur = useLed ? tiltLed : motorPwm;
				if (!cur)
					fell = 1'b1;
				else
					width++;
			end
		end
	endtask

	// Expected 0 means never high and PWM_PERIOD means always high
	task automatic judgeChannel(input string sigName, input int expTicks, input int width,
		input bit rose, input bit fell, input bit changed, input logic firstLevel);
		if (rose && fell)
			checkWidth(sigName, width, expTicks * TICK_DIV);
		else if (!changed && (expTicks == 0 || expTicks >= PWM_PERIOD))
			checkLevel(sigName, firstLevel, logic'(expTicks != 0));
		else if (!changed)
			reportFailure($sformatf("%s stayed at %b for a whole frame instead of pulsing",
				sigName, firstLevel));
		else if (!rose)
			reportFailure($sformatf("%s showed no rising edge within one frame", sigName));
		else
			reportFailure($sformatf("%s showed no falling edge within one frame", sigName));
	endtask

	task automatic runTest(input int idx, input bit settle);
		int   errorsBefore;
		int   motorWidth;
		int   ledWidth;
		bit   motorRose;
		bit   motorFell;
		bit   motorChanged;
		bit   ledRose;
		bit   ledFell;
		bit   ledChanged;
		logic motorFirst;
		logic ledFirst;
		errorsBefore = errorCount;
		// Back-to-back strobes replace every filter tap, so earlier tests leave no trace
		for (int i = 0; i < FILTER_TAPS; i++)
		begin
			@(posedge CLOCK_50);
			#1;
			accelSample = tiltSample_t'(testSamples[idx * FILTER_TAPS + i]);
			accelStrobe = 1'b1;
		end
		@(posedge CLOCK_50);
		#1;
		accelStrobe = 1'b0;
		// Two frames let the new average settle past any mid-frame change
		// Straight after reset the samples are in before the first tick, so the first frame counts
		if (settle)
			repeat (2 * FRAME_CYCLES) @(posedge CLOCK_50);
		fork
			measurePulse(1'b0, motorWidth, motorRose, motorFell, motorChanged, motorFirst);
			measurePulse(1'b1, ledWidth, ledRose, ledFell, ledChanged, ledFirst);
		join
		judgeChannel("motorPwm", expMotor[idx], motorWidth, motorRose, motorFell,
			motorChanged, motorFirst);
		judgeChannel("tiltLed", expLed[idx], ledWidth, ledRose, ledFell, ledChanged, ledFirst);
		if (errorCount == errorsBefore)
			$display("Test %-16s passed", testNames[idx]);
		else
		begin
			$display("Test %-16s failed", testNames[idx]);
			failedTests++;
		end
	endtask

	initial
	begin
		arstN = 1'b0;
		accelSample = '0;
		accelStrobe = 1'b0;
		readTrace();
		numTests = testNames.size();
		if (numTests == 0)
			reportFailure("The trace file holds no test lines");
		traceReady = 1'b1;
		repeat (5) @(posedge CLOCK_50);
		#1;
		arstN = 1'b1;
		// Both outputs are still low straight after reset release
		checkLevel("motorPwm", motorPwm, 1'b0);
		checkLevel("tiltLed", tiltLed, 1'b0);
		$display("Test %-16s %s", "reset", (errorCount == 0) ? "passed" : "failed");
		if (errorCount != 0)
			failedTests++;
		// The first test times the very first pulses after reset
		for (int i = 0; i < numTests; i++)
			runTest(i, i != 0);
		$display("%0d tests run, %0d passed, %0d failed, %0d errors", numTests + 1,
			numTests + 1 - failedTests, failedTests, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Each test needs about four frames, so five per test plus reset leaves margin
	initial
	begin
		longint limitNs;
		wait (traceReady);
		limitNs = (longint'(numTests) * 5 + 2) * FRAME_CYCLES * CLK_PERIOD;
		#limitNs;
		$display("Timeout: the run did not finish within %0d ns", limitNs);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/bikeDriveTrace.txt
# Columns: name sample0 sample1 sample2 sample3 motorTicks ledTicks
# Ticks are high time per frame, where 0 is never high and 531 is always high
# Forward tilt
fwd_small      40   40   40   40   290  40
fwd_mid       100  100  100  100   350 100
fwd_again      70   70   70   70   320  70
just_above     13   13   13   13   263  13
# Dead zone
dz_zero         0    0    0    0     0   0
dz_edge_pos    12   12   12   12     0   0
dz_edge_neg   -12  -12  -12  -12     0   0
# Backward tilt
back_small    -50  -50  -50  -50     0  50
back_big     -200 -200 -200 -200     0 200
back_max     -512 -512 -512 -512     0 512
# Saturation
sat_below     280  280  280  280   530 280
sat_edge      281  281  281  281   531 281
sat_full      400  400  400  400   531 400
sat_max       511  511  511  511   531 511
# Averaging with unequal samples
avg_mixed     100  -20   60   -4   284  34
avg_floor_pos  13   14   14   14   263  13
avg_floor_neg -13  -14  -14  -14     0  14
avg_mixed_back -100  30  -60   -1    0  33
avg_dz_mixed   60  -60   20  -10     0   0
avg_last_big    0    0    0  200   300  50
avg_last_neg  300  300 -100 -100   350 100
avg_neg_floor -50  -50  -50   49     0  26
avg_big_mix   400  400  400 -300   475 225

//--- project.f
hw/bikeDrivePkg.sv
hw/pwmPrescaler.sv
hw/tiltFilter.sv
hw/pwmGenerator.sv
hw/bikeDrive.sv
bench/bikeDrive_props.sv
bench/bikeDriveTb.sv

//--- Makefile
# Verilator build and run of the drive-control testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module bikeDriveTb -f project.f -Mdir obj_dir
	-./obj_dir/VbikeDriveTb > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
